//--- bench/ca_vectors.txt
// Each case: rule, seed mode (1 = random), frame count, then one
// live-cell count per frame; fff means the count comes from the model
// A frame count of 0 ends the list
// Rule 90 from the dot, triangle folded at the left edge
05a 000 002
11c 11c
// Rule 184 dot drifts right and leaves past column 63
0b8 000 002
020 020
// Rule 255 fills every row after the first
0ff 000 001
bc1
// Rule 30 and rule 110 from the dot
01e 000 001
fff
06e 000 001
fff
// Random seed rows from the LFSR bank
01e 001 003
fff fff fff
06e 001 002
fff fff
05a 001 003
fff fff fff
0b8 001 001
fff
// End of list
000 000 000

//--- sim.f
+incdir+bench
verilog/ca_pkg.sv
verilog/seed_lfsr_bank.sv
verilog/ca_cell.sv
verilog/ca_sequencer.sv
verilog/ca_top.sv
bench/ca_tb.sv

//--- bench/ca_model.svh
//////////////////////////////////////////////////////////////////////
// Automaton reference model and compare tasks
// LFSR lane step and rule step for the expected rows, plus one
// compare task for each kind of DUT result
//////////////////////////////////////////////////////////////////////

`ifndef CA_MODEL_SVH
`define CA_MODEL_SVH

// One lane step with taps at 31, 21, 1 and 0
function automatic logic [31:0] model_lane_step(input logic [31:0] lane);
   return {lane[30:0], lane[31] ^ lane[21] ^ lane[1] ^ lane[0]};
endfunction

// Whole bank with lane 0 in the low word
function automatic ca_pkg::row_t model_bank_step(input ca_pkg::row_t bank);
   return {model_lane_step(bank[63:32]), model_lane_step(bank[31:0])};
endfunction

// Next generation with a dead cell beyond each edge
function automatic ca_pkg::row_t model_generation
(
   input ca_pkg::row_t  cur,
   input ca_pkg::rule_t rule
);
   ca_pkg::row_t nxt;
   logic         l;
   logic         r;
   int           idx;
   for (int i = 0; i < ca_pkg::row_width; i++)
   begin
      l      = (i == 0) ? 1'b0 : cur[i-1];                      // Left edge pad
      r      = (i == ca_pkg::row_width - 1) ? 1'b0 : cur[i+1];  // Right edge pad
      idx    = int'(l) * 4 + int'(cur[i]) * 2 + int'(r);
      nxt[i] = rule[idx];
   end
   return nxt;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
   $display("[ERROR] time %0d ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
   stop_with_failure("");
endtask

// Pixel position and value
task automatic check_pixel(input ca_pkg::x_t exp_x, input ca_pkg::y_t exp_y,
                           input logic exp_data, input ca_pkg::x_t act_x,
                           input ca_pkg::y_t act_y, input logic act_data);
   if (act_x !== exp_x) report_mismatch("pix_x", exp_x, act_x);
   if (act_y !== exp_y) report_mismatch("pix_y", exp_y, act_y);
   if (act_data !== exp_data) report_mismatch("pix_data", exp_data, act_data);
endtask

task automatic check_count(input ca_pkg::live_count_t exp_n, input ca_pkg::live_count_t act_n);
   if (act_n !== exp_n) report_mismatch("live count", exp_n, act_n);
endtask

task automatic check_done(input logic exp_d, input logic act_d);
   if (act_d !== exp_d) report_mismatch("done", exp_d, act_d);
endtask

task automatic check_strobe(input logic exp_we, input logic act_we);
   if (act_we !== exp_we) report_mismatch("pix_we", exp_we, act_we);
endtask

`endif

//--- bench/ca_tb.sv
//////////////////////////////////////////////////////////////////////
// Cellular automaton testbench
// Runs each case of the vector file through ca_top and checks every
// pixel, the frame timing, the restart key and the live counts
//////////////////////////////////////////////////////////////////////

module ca_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int vec_depth  = 64;                // Words in the vector memory
   localparam int wait_limit = 40;                // Cycles allowed before pix_we
   localparam ca_pkg::live_count_t from_model = 12'hfff;   // No count given for the frame

   logic                VGA_CTRL_CLK;
   logic                reset;
   ca_pkg::rule_t       rule_sw;
   logic                random_seed;
   logic                restart_n;
   logic                pix_we;
   ca_pkg::x_t          pix_x;
   ca_pkg::y_t          pix_y;
   logic                pix_data;
   logic                done;

   ca_pkg::live_count_t vec_mem [0:vec_depth-1];  // Flat case list
   ca_pkg::row_t        model_bank;               // Model LFSR lanes
   ca_pkg::row_t        model_row;                // Model cell row

   `include "ca_model.svh"

   ca_top dut
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .rule_sw      (rule_sw),
      .random_seed  (random_seed),
      .restart_n    (restart_n),
      .pix_we       (pix_we),
      .pix_x        (pix_x),
      .pix_y        (pix_y),
      .pix_data     (pix_data),
      .done         (done)
   );

   // 40 ns clock
   initial
   begin
      VGA_CTRL_CLK = 1'b0;
      forever #20 VGA_CTRL_CLK = ~VGA_CTRL_CLK;
   end

   task automatic stop_with_failure(input string why);
      if (why != "") $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   // Frame start seen on the falling edge
   task automatic wait_for_pix_we();
      int n;
      n = 0;
      @(negedge VGA_CTRL_CLK);
      while (pix_we !== 1'b1)
      begin
         if (n == wait_limit) stop_with_failure("pix_we never rose after the load cycle");
         n++;
         @(negedge VGA_CTRL_CLK);
      end
   endtask

   // Done held with no writes
   task automatic idle_checks(input int cycles);
      repeat (cycles)
      begin
         @(negedge VGA_CTRL_CLK);
         check_done(1'b1, done);
         check_strobe(1'b0, pix_we);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // One frame of pixel writes against the model
   //////////////////////////////////////////////////////////////////////
   task automatic scan_frame(input ca_pkg::rule_t rule, input ca_pkg::live_count_t want);
      ca_pkg::live_count_t seen;
      seen = '0;
      wait_for_pix_we();
      for (int y = 0; y < ca_pkg::row_count; y++)
      begin
         for (int x = 0; x < ca_pkg::row_width; x++)
         begin
            check_strobe(1'b1, pix_we);
            check_done(1'b0, done);
            check_pixel(ca_pkg::x_t'(x), ca_pkg::y_t'(y), model_row[x], pix_x, pix_y, pix_data);
            seen = seen + ca_pkg::live_count_t'(pix_data);
            @(negedge VGA_CTRL_CLK);
         end
         model_row = model_generation(model_row, rule);
         if (y < ca_pkg::row_count - 1)
         begin
            check_strobe(1'b0, pix_we);     // Step cycle between rows
            check_done(1'b0, done);
            @(negedge VGA_CTRL_CLK);
         end
      end
      check_strobe(1'b0, pix_we);
      check_done(1'b1, done);               // Rises right after the last pixel
      if (want != from_model)
      begin
         check_count(want, seen);           // Count from the vector file
      end
   endtask

   // Key press and release while the rule switches move
   task automatic restart_frame(input logic random_mode);
      idle_checks($urandom % 5);
      @(posedge VGA_CTRL_CLK);
      rule_sw <= ~rule_sw;
      @(posedge VGA_CTRL_CLK);
      restart_n <= 1'b0;
      idle_checks(16 + $urandom % 8);       // Held key starts nothing
      @(posedge VGA_CTRL_CLK);
      restart_n <= 1'b1;
      if (random_mode)
      begin
         model_bank = model_bank_step(model_bank);
         model_row  = model_bank;
      end
      else
         model_row = ca_pkg::row_t'(1) << ca_pkg::center_col;
   endtask

   task automatic run_case(input ca_pkg::rule_t rule, input logic random_mode,
                           input int frames, input int base);
      @(posedge VGA_CTRL_CLK);
      reset       <= 1'b1;
      rule_sw     <= rule;
      random_seed <= random_mode;
      restart_n   <= 1'b1;
      repeat (7) @(posedge VGA_CTRL_CLK);
      @(negedge VGA_CTRL_CLK);
      check_done(1'b0, done);               // Outputs low in reset
      check_strobe(1'b0, pix_we);
      check_pixel('0, '0, 1'b0, pix_x, pix_y, pix_data);
      @(posedge VGA_CTRL_CLK);
      reset <= 1'b0;
      model_bank = ca_pkg::seed_row;
      model_row  = random_mode ? model_bank : ca_pkg::row_t'(1) << ca_pkg::center_col;
      for (int f = 0; f < frames; f++)
      begin
         if (f > 0) restart_frame(random_mode);
         scan_frame(rule, vec_mem[base+f]);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      int idx;
      int frames;
      int cases_run;
      reset       = 1'b1;
      rule_sw     = '0;
      random_seed = 1'b0;
      restart_n   = 1'b1;
      void'($urandom(32'hc3dd_44b0));
      $readmemh("bench/ca_vectors.txt", vec_mem);
      idx       = 0;
      frames    = 1;
      cases_run = 0;
      while (frames != 0)
      begin
         if (idx + 3 > vec_depth || $isunknown(vec_mem[idx+2]))
            stop_with_failure("vector file ends without a zero frame count");
         frames = int'(vec_mem[idx+2]);
         if (frames != 0)
         begin
            if (idx + 3 + frames > vec_depth)
               stop_with_failure("vector file case runs past the end of memory");
            run_case(vec_mem[idx][7:0], vec_mem[idx+1][0], frames, idx + 3);
            cases_run++;
            idx = idx + 3 + frames;
         end
      end
      if (cases_run == 0)
         stop_with_failure("vector file holds no test cases");
      else
      begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

//--- verilog/ca_top.sv
//////////////////////////////////////////////////////////////////////
// Cellular automaton top level
// Connects the seed LFSR bank, one row of automaton cells and the
// frame sequencer that streams generations out as pixel writes
//////////////////////////////////////////////////////////////////////

module ca_top
(
   input  logic          VGA_CTRL_CLK,
   input  logic          reset,
   input  ca_pkg::rule_t rule_sw,       // Rule switches
   input  logic          random_seed,   // Seed mode switch
   input  logic          restart_n,     // Restart key
   output logic          pix_we,        // Pixel write strobe
   output ca_pkg::x_t    pix_x,         // Pixel column
   output ca_pkg::y_t    pix_y,         // Pixel row
   output logic          pix_data,      // Pixel value
   output logic          done           // Frame complete
);

   ca_pkg::row_t                 random_row;   // LFSR seed row
   ca_pkg::row_t                 row;          // Gathered cell states
   logic [ca_pkg::row_width+1:0] padded;       // Row with zero edges
   ca_pkg::rule_t                rule;
   logic                         use_random;
   logic                         load;
   logic                         step;
   logic                         advance;

   // Zero cell beyond each edge
   assign padded = {1'b0, row, 1'b0};

   //////////////////////////////////////////////////////////////////
   // Seed source
   //////////////////////////////////////////////////////////////////
   seed_lfsr_bank u_lfsr
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .advance      (advance),
      .random_row   (random_row)
   );

   //////////////////////////////////////////////////////////////////
   // Cell row
   //////////////////////////////////////////////////////////////////
   // Column n sees padded[n] on its left and padded[n+2] on its right
   for (genvar i = 0; i < ca_pkg::row_width; i++)
   begin : g_cell
      ca_cell u_cell
      (
         .VGA_CTRL_CLK (VGA_CTRL_CLK),
         .reset        (reset),
         .rule         (rule),
         .left         (padded[i]),
         .right        (padded[i+2]),
         .load         (load),
         .step         (step),
         .use_random   (use_random),
         .random_bit   (random_row[i]),
         .dot_bit      (i == ca_pkg::center_col),   // Centre tie only
         .state        (row[i])
      );
   end

   //////////////////////////////////////////////////////////////////
   // Frame control
   //////////////////////////////////////////////////////////////////
   ca_sequencer u_seq
   (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .rule_sw      (rule_sw),
      .random_seed  (random_seed),
      .restart_n    (restart_n),
      .row          (row),
      .rule         (rule),
      .use_random   (use_random),
      .load         (load),
      .step         (step),
      .advance      (advance),
      .pix_we       (pix_we),
      .pix_x        (pix_x),
      .pix_y        (pix_y),
      .pix_data     (pix_data),
      .done         (done)
   );

endmodule

//--- verilog/ca_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Frame sequencer
// Latches rule and seed mode at reset, seeds the row, streams each
// generation out as pixel writes, steps the cells between rows and
// handles the restart key once the frame is done
//////////////////////////////////////////////////////////////////////

module ca_sequencer
(
   input  logic          VGA_CTRL_CLK,
   input  logic          reset,
   input  ca_pkg::rule_t rule_sw,       // Rule switches
   input  logic          random_seed,   // Seed mode switch
   input  logic          restart_n,     // Restart key, low when pressed
   input  ca_pkg::row_t  row,           // Cell states, bit n is column n
   output ca_pkg::rule_t rule,          // Rule to every cell
   output logic          use_random,    // Seed mode to every cell
   output logic          load,          // Seed load pulse
   output logic          step,          // Generation step pulse
   output logic          advance,       // LFSR bank step pulse
   output logic          pix_we,        // Pixel write strobe
   output ca_pkg::x_t    pix_x,         // Pixel column
   output ca_pkg::y_t    pix_y,         // Pixel row
   output logic          pix_data,      // Pixel value
   output logic          done           // Frame complete
);

   //////////////////////////////////////////////////////////////////
   // State encoding
   //////////////////////////////////////////////////////////////////
   typedef enum logic [2:0]
   {
      st_load,                           // Seed the row
      st_scan,                           // Stream one row of pixels
      st_step,                           // Compute next generation
      st_idle,                           // Frame shown, wait for press
      st_wait_release                    // Key held, wait for release
   } state_t;

   state_t        state;
   ca_pkg::x_t    col;                   // Column counter
   ca_pkg::y_t    row_cnt;               // Row counter
   ca_pkg::rule_t rule_q;                // Rule latched at reset
   logic          use_random_q;          // Mode latched at reset

   logic          last_pixel;            // Final column of a row
   logic          last_line;             // Final row of the frame

   assign last_pixel = (col == ca_pkg::last_col);
   assign last_line  = (row_cnt == ca_pkg::last_row);

   //////////////////////////////////////////////////////////////////
   // Switch latch
   //////////////////////////////////////////////////////////////////
   // Switches are only sampled while reset is held
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         rule_q       <= rule_sw;
         use_random_q <= random_seed;
      end
   end

   //////////////////////////////////////////////////////////////////
   // Frame state machine and counters
   //////////////////////////////////////////////////////////////////
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         state   <= st_load;             // First cycle out of reset loads
         col     <= '0;
         row_cnt <= '0;
      end
      else
      begin
         case (state)
            st_load:
            begin
               // Cells take their seed at the end of this cycle
               col     <= '0;
               row_cnt <= '0;
               state   <= st_scan;
            end

            st_scan:
            begin
               if (last_pixel)
               begin
                  col <= '0;             // Wrap for the next row
                  if (last_line)
                  begin
                     state <= st_idle;   // Whole frame written
                  end
                  else
                  begin
                     state <= st_step;
                  end
               end
               else
               begin
                  col <= col + 1'b1;
               end
            end

            st_step:
            begin
               // Cells update on this edge, next row follows
               row_cnt <= row_cnt + 1'b1;
               state   <= st_scan;
            end

            st_idle:
            begin
               if (!restart_n)
               begin
                  state <= st_wait_release;   // Key pressed
               end
            end

            st_wait_release:
            begin
               if (restart_n)
               begin
                  state <= st_load;      // Released, new frame
               end
            end

            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////
   // Decoded outputs
   //////////////////////////////////////////////////////////////////
   assign rule       = rule_q;
   assign use_random = use_random_q;

   assign load    = (state == st_load);
   assign step    = (state == st_step);
   // Release cycle only, so the bank has moved by the load cycle
   assign advance = (state == st_wait_release) && restart_n;

   assign pix_we   = (state == st_scan);
   assign pix_x    = col;
   assign pix_y    = row_cnt;
   assign pix_data = pix_we & row[col];  // Cell at the scan column

   // Held through the whole restart handshake
   assign done = (state == st_idle) || (state == st_wait_release);

endmodule

//--- verilog/ca_cell.sv
//////////////////////////////////////////////////////////////////////
// Automaton cell
// One state bit; loads a seed or applies the rule to its
// three-cell neighbourhood
//////////////////////////////////////////////////////////////////////

module ca_cell
(
   input  logic          VGA_CTRL_CLK,
   input  logic          reset,
   input  ca_pkg::rule_t rule,          // Latched rule number
   input  logic          left,          // Column minus one
   input  logic          right,         // Column plus one
   input  logic          load,          // Seed load pulse
   input  logic          step,          // Generation step pulse
   input  logic          use_random,    // Seed from LFSR row
   input  logic          random_bit,    // This column of the LFSR row
   input  logic          dot_bit,       // High only at the centre column
   output logic          state          // Current cell value
);

   logic [2:0] hood;                     // Neighbourhood index
   logic       seed_bit;                 // Seed for the current mode

   // Left is the MSB of the index
   assign hood     = {left, state, right};
   assign seed_bit = use_random ? random_bit : dot_bit;

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         state <= 1'b0;
      end
      else if (load)
      begin
         state <= seed_bit;              // Start of a frame
      end
      else if (step)
      begin
         state <= rule[hood];            // Rule bit at the index
      end
   end

   // Holds its value between pulses while the row is scanned

endmodule

//--- verilog/seed_lfsr_bank.sv
//////////////////////////////////////////////////////////////////////
// Seed LFSR bank
// Holds one 32-bit Fibonacci LFSR per lane, together forming a full
// pseudo-random row; every lane steps once per advance pulse
//////////////////////////////////////////////////////////////////////

module seed_lfsr_bank
(
   input  logic         VGA_CTRL_CLK,
   input  logic         reset,
   input  logic         advance,         // One-cycle step request
   output ca_pkg::row_t random_row       // All lanes side by side
);

   // One lane step
   // Shift left, new low bit from the tapped XOR
   function automatic logic [ca_pkg::lane_width-1:0] lane_step
   (
      input logic [ca_pkg::lane_width-1:0] lane
   );
      logic fb;
      fb = ^(lane & ca_pkg::lane_taps);
      return {lane[ca_pkg::lane_width-2:0], fb};
   endfunction

   //////////////////////////////////////////////////////////////////
   // Lane registers
   //////////////////////////////////////////////////////////////////
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         random_row <= ca_pkg::seed_row;     // Known starting row
      end
      else if (advance)
      begin
         // Every lane moves together
         for (int k = 0; k < ca_pkg::lane_count; k++)
         begin
            random_row[k*ca_pkg::lane_width +: ca_pkg::lane_width] <=
               lane_step(random_row[k*ca_pkg::lane_width +: ca_pkg::lane_width]);
         end
      end
   end

   // Lane 0 sits in the low word, lane 1 above it
   // Bit n of the row seeds column n

endmodule

//--- verilog/ca_pkg.sv
//////////////////////////////////////////////////////////////////////
// Cellular automaton shared definitions
// Row and frame geometry, LFSR lane layout, seed constant and the
// common data types used across the automaton datapath
//////////////////////////////////////////////////////////////////////

package ca_pkg;

   //////////////////////////////////////////////////////////////////
   // Frame geometry
   //////////////////////////////////////////////////////////////////
   localparam int row_width  = 64;                // Cells per row
   localparam int row_count  = 48;                // Rows per frame
   localparam int center_col = 32;                // Single dot seed column

   //////////////////////////////////////////////////////////////////
   // LFSR bank layout
   //////////////////////////////////////////////////////////////////
   localparam int lane_width = 32;                // Bits per lane
   localparam int lane_count = row_width / lane_width;

   // Feedback taps at bits 31, 21, 1 and 0
   localparam logic [lane_width-1:0] lane_taps = 32'h8020_0003;

   // Power-on contents of the bank, lane 0 in the low word
   localparam logic [row_width-1:0] seed_row = 64'h1f64_ff19_7a07_037e;

   //////////////////////////////////////////////////////////////////
   // Data types
   //////////////////////////////////////////////////////////////////
   typedef logic [5:0]           x_t;             // Pixel column
   typedef logic [5:0]           y_t;             // Pixel row
   typedef logic [7:0]           rule_t;          // Wolfram rule number
   typedef logic [row_width-1:0] row_t;           // Bit n is column n
   typedef logic [11:0]          live_count_t;    // Live cells in a frame

   // Last column and row of a frame in counter widths
   localparam x_t last_col = x_t'(row_width - 1);
   localparam y_t last_row = y_t'(row_count - 1);

endpackage
